// ==== src/ppu_video_pkg.sv ====
package ppu_video_pkg;

    // ======================================================================
    // Widths and depths
    // ======================================================================
    localparam int pal_addr_w  = 9;                // Palette word address
    localparam int pal_depth   = 1 << pal_addr_w;  // 512 words of two entries
    localparam int row_addr_w  = 9;                // Row-buffer entry address
    localparam int row_depth   = 1 << row_addr_w;  // Entries per bank
    localparam int host_addr_w = 11;
    localparam int host_data_w = 32;

    // Upper bits pick the palette word, bit 0 picks the entry in it
    typedef logic [pal_addr_w:0] pal_index_t;

    // ======================================================================
    // Palette types
    // ======================================================================
    typedef struct packed {
        logic [7:0] unused;  // Pad to 32 bits
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } palette_entry_t;

    // One RAM word, seen whole or as two entries (entry 1 in the upper half)
    typedef union packed {
        logic [63:0]               raw;
        palette_entry_t [1:0]      entry;
    } palette_word_u;

    typedef struct packed {
        logic [1:0]            half_en;  // Bit 1 writes entry 1
        logic [pal_addr_w-1:0] addr;
        palette_word_u         word;
    } pal_wr_t;

    // ======================================================================
    // Bus types
    // ======================================================================
    typedef struct packed {
        logic                  en;
        logic [row_addr_w-1:0] addr;
        pal_index_t            data;
    } row_wr_t;

    // addr[10] set selects the control register, else palette entry addr[9:0]
    typedef struct packed {
        logic                   en;
        logic [host_addr_w-1:0] addr;
        logic [host_data_w-1:0] data;
    } host_wr_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage : ppu_video_pkg

// ==== src/video_host_regs.sv ====
module video_host_regs
    import ppu_video_pkg::*;
(
    input  logic     video_clk,
    input  logic     rst_n,
    input  host_wr_t host,
    output pal_wr_t  pal_wr,
    output logic     display_en
);

    logic                  ctrl_sel;    // Address bit 10 picks control space
    logic [1:0]            wr_half_en;
    logic [pal_addr_w-1:0] wr_addr;
    palette_word_u         wr_word;

    assign ctrl_sel = host.addr[host_addr_w-1];

    // ======================================================================
    // Palette write path
    // ======================================================================
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_half_en <= 2'b00;
        end else if (host.en && !ctrl_sel) begin
            wr_half_en <= host.addr[0] ? 2'b10 : 2'b01;  // One entry per write
        end else begin
            wr_half_en <= 2'b00;
        end
    end

    // Entry copied into both halves, half_en picks the live one
    always_ff @(posedge video_clk) begin
        if (host.en && !ctrl_sel) begin
            wr_addr          <= host.addr[pal_addr_w:1];
            wr_word.entry[0] <= host.data;
            wr_word.entry[1] <= host.data;
        end
    end

    assign pal_wr.half_en = wr_half_en;
    assign pal_wr.addr    = wr_addr;
    assign pal_wr.word    = wr_word;

    // ======================================================================
    // Control register
    // ======================================================================
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            display_en <= 1'b0;
        end else if (host.en && ctrl_sel) begin
            display_en <= host.data[0];  // Bit 0 turns the picture on
        end
    end

    // Only one control register is mapped
    ctrl_addr_mapped: assert property (@(posedge video_clk) disable iff (!rst_n)
        host.en && ctrl_sel |-> host.addr == 11'h400)
        else $error("Host write to unmapped control address %h", host.addr);

endmodule : video_host_regs

// ==== src/ppu_palette_ram.sv ====
module ppu_palette_ram
    import ppu_video_pkg::*;
(
    input  logic                  video_clk,
    input  logic                  rst_n,
    input  pal_wr_t               wr,
    input  logic [pal_addr_w-1:0] rdaddr,
    output palette_word_u         rddata
);

    logic [63:0] pal_mem [pal_depth];  // Two entries per word

    // Each half written only when its enable is set
    always_ff @(posedge video_clk) begin
        if (wr.half_en[0])
            pal_mem[wr.addr][31:0] <= wr.word.raw[31:0];
        if (wr.half_en[1])
            pal_mem[wr.addr][63:32] <= wr.word.raw[63:32];
    end

    // Registered read
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            rddata.raw <= '0;
        end else begin
            rddata.raw <= pal_mem[rdaddr];
        end
    end

endmodule : ppu_palette_ram

// ==== src/ppu_row_buffer.sv ====
module ppu_row_buffer
    import ppu_video_pkg::*;
#(
    parameter int unsigned row_len = 320  // Indices per line
) (
    input  logic                  video_clk,
    input  logic                  rst_n,
    input  logic                  swap,
    input  row_wr_t               wr,
    input  logic [row_addr_w-1:0] rdaddr,
    output pal_index_t            rddata
);

    pal_index_t bank_mem [2][row_depth];  // Front and back banks
    logic       front_sel;                // Bank currently scanned out

    // Front flag flips once per line
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            front_sel <= 1'b0;
        end else if (swap) begin
            front_sel <= !front_sel;
        end
    end

    // Writer fills the back bank while the front one is read
    always_ff @(posedge video_clk) begin
        if (wr.en)
            bank_mem[!front_sel][wr.addr] <= wr.data;
        rddata <= bank_mem[front_sel][rdaddr];  // One cycle latency
    end

    // Both sides stay inside one line of indices
    addr_in_row: assert property (@(posedge video_clk) disable iff (!rst_n)
        (!wr.en || wr.addr < row_len) && rdaddr < row_len)
        else $error("Row-buffer address beyond row length %0d", row_len);

endmodule : ppu_row_buffer

// ==== src/hdmi_video_output.sv ====
module hdmi_video_output
    import ppu_video_pkg::*;
#(
    parameter logic [9:0] h_visible    = 10'd640,
    parameter logic [9:0] h_frontporch = 10'd16,
    parameter logic [9:0] h_sync       = 10'd96,
    parameter logic [9:0] h_backporch  = 10'd48,
    parameter logic [9:0] h_total      = 10'd800,
    parameter logic [9:0] v_visible    = 10'd480,
    parameter logic [9:0] v_frontporch = 10'd10,
    parameter logic [9:0] v_sync       = 10'd2,
    parameter logic [9:0] v_backporch  = 10'd33,
    parameter logic [9:0] v_total      = 10'd525
) (
    input  logic                  video_clk,
    input  logic                  rst_n,
    input  logic                  display_en,
    // HDMI transmitter side
    output logic                  vga_pclk,
    output logic                  vga_de,
    output logic                  vga_hs,
    output logic                  vga_vs,
    output rgb_t                  vga_rgb,
    // Row buffer and palette fetch
    input  pal_index_t            rowram_rddata,
    output logic [row_addr_w-1:0] rowram_rdaddr,
    input  palette_word_u         palram_rddata,
    output logic [pal_addr_w-1:0] palram_rdaddr,
    output logic                  rowram_swap
);

    // Visible window edges, sync sits at count 0
    localparam logic [9:0] h_start = h_sync + h_backporch;
    localparam logic [9:0] h_end   = h_start + h_visible;
    localparam logic [9:0] v_start = v_sync + v_backporch;
    localparam logic [9:0] v_end   = v_start + v_visible;

    // Front porch is implied by total, kept to tie the timing set together
    initial assert (h_end + h_frontporch == h_total && v_end + v_frontporch == v_total)
        else $error("Porch and total parameters disagree");

    typedef enum logic [1:0] { idle, swap, display } line_state_t;

    // ======================================================================
    // Signals
    // ======================================================================
    logic [9:0]            h_count, h_next;
    logic [9:0]            v_count, v_next;
    logic                  de_next;          // Display enable one cycle ahead
    line_state_t           c_state, n_state;
    logic                  addr_toggle, n_addr_toggle;  // Two pixels per index
    logic [row_addr_w-1:0] n_rowram_rdaddr;
    logic                  palram_datasel;       // Entry select, aligned to palram_rdaddr
    logic                  palram_datasel_prev;  // Aligned to palram_rddata
    palette_entry_t        pix_entry;
    rgb_t                  n_vga_rgb;

    // ======================================================================
    // Raster timing
    // ======================================================================
    assign vga_pclk = video_clk;

    always_comb begin
        h_next = (h_count == h_total - 10'd1) ? 10'd0 : h_count + 10'd1;
        v_next = v_count;
        if (h_count == h_total - 10'd1)  // Advance at end of line
            v_next = (v_count == v_total - 10'd1) ? 10'd0 : v_count + 10'd1;
    end

    assign vga_de = (h_count >= h_start) && (h_count < h_end) &&
                    (v_count >= v_start) && (v_count < v_end);
    assign de_next = (h_next >= h_start) && (h_next < h_end) &&
                     (v_next >= v_start) && (v_next < v_end);

    assign vga_hs = !(h_count < h_sync);  // Active low
    assign vga_vs = !(v_count < v_sync);

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= 10'd0;
            v_count <= 10'd0;
        end else begin
            h_count <= h_next;
            v_count <= v_next;
        end
    end

    // ======================================================================
    // Per-line FSM and fetch addressing
    // ======================================================================
    // Select picks the entry half of the word through the union
    assign pix_entry = palram_rddata.entry[palram_datasel_prev];

    always_comb begin
        n_state         = c_state;
        rowram_swap     = 1'b0;
        n_rowram_rdaddr = rowram_rdaddr;
        n_addr_toggle   = 1'b0;
        n_vga_rgb       = '0;  // Black outside the window
        unique case (c_state)
            idle: begin
                if (h_count == h_start - 10'd6)
                    n_state = swap;  // Swap lands 5 cycles before first column
            end
            swap: begin
                rowram_swap     = 1'b1;
                n_rowram_rdaddr = '0;  // Restart the row
                n_state         = display;
            end
            display: begin
                // Step the index every second cycle, stop on the last one
                if (addr_toggle && h_count < h_end - 10'd5)
                    n_rowram_rdaddr = rowram_rdaddr + 1'b1;
                n_addr_toggle = !addr_toggle;
                if (h_count == h_end - 10'd1)
                    n_state = idle;
            end
            default: n_state = idle;
        endcase
        // Colour only where the next cycle is displayed
        if (de_next && display_en)
            n_vga_rgb = '{red: pix_entry.red, green: pix_entry.green, blue: pix_entry.blue};
    end

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            c_state             <= idle;
            addr_toggle         <= 1'b0;
            rowram_rdaddr       <= '0;
            palram_rdaddr       <= '0;
            palram_datasel      <= 1'b0;
            palram_datasel_prev <= 1'b0;
            vga_rgb             <= '0;
        end else begin
            c_state             <= n_state;
            addr_toggle         <= n_addr_toggle;
            rowram_rdaddr       <= n_rowram_rdaddr;
            palram_rdaddr       <= rowram_rddata[pal_addr_w:1];  // Word address
            palram_datasel      <= rowram_rddata[0];
            palram_datasel_prev <= palram_datasel;  // Match palette read latency
            vga_rgb             <= n_vga_rgb;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    swap_single_cycle: assert property (@(posedge video_clk) disable iff (!rst_n)
        rowram_swap |-> (h_count == h_start - 10'd5) ##1 !rowram_swap)
        else $error("rowram_swap off its column or held for two cycles");

    black_in_blank: assert property (@(posedge video_clk) disable iff (!rst_n)
        !vga_de |-> vga_rgb == '0)
        else $error("Colour driven outside the display window");

endmodule : hdmi_video_output

// ==== src/ppu_video_top.sv ====
module ppu_video_top
    import ppu_video_pkg::*;
#(
    parameter logic [9:0] h_visible    = 10'd640,
    parameter logic [9:0] h_frontporch = 10'd16,
    parameter logic [9:0] h_sync       = 10'd96,
    parameter logic [9:0] h_backporch  = 10'd48,
    parameter logic [9:0] h_total      = 10'd800,
    parameter logic [9:0] v_visible    = 10'd480,
    parameter logic [9:0] v_frontporch = 10'd10,
    parameter logic [9:0] v_sync       = 10'd2,
    parameter logic [9:0] v_backporch  = 10'd33,
    parameter logic [9:0] v_total      = 10'd525
) (
    input  logic     video_clk,
    input  logic     rst_n,
    input  host_wr_t host,      // Host register writes
    input  row_wr_t  row_wr,    // Next line from the picture processor
    output logic     row_swap,  // Line boundary toward the picture processor
    output logic     vga_pclk,
    output logic     vga_de,
    output logic     vga_hs,
    output logic     vga_vs,
    output rgb_t     vga_rgb
);

    pal_wr_t               pal_wr;
    logic                  display_en;
    logic [row_addr_w-1:0] rowram_rdaddr;
    pal_index_t            rowram_rddata;
    logic                  rowram_swap;
    logic [pal_addr_w-1:0] palram_rdaddr;
    palette_word_u         palram_rddata;

    assign row_swap = rowram_swap;

    video_host_regs video_host_regs_inst (
        .video_clk  (video_clk),
        .rst_n      (rst_n),
        .host       (host),
        .pal_wr     (pal_wr),
        .display_en (display_en)
    );

    ppu_palette_ram ppu_palette_ram_inst (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .wr        (pal_wr),
        .rdaddr    (palram_rdaddr),
        .rddata    (palram_rddata)
    );

    // Half horizontal resolution, one index per two pixels
    ppu_row_buffer #(
        .row_len (h_visible / 2)
    ) ppu_row_buffer_inst (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .swap      (rowram_swap),
        .wr        (row_wr),
        .rdaddr    (rowram_rdaddr),
        .rddata    (rowram_rddata)
    );

    hdmi_video_output #(
        .h_visible    (h_visible),
        .h_frontporch (h_frontporch),
        .h_sync       (h_sync),
        .h_backporch  (h_backporch),
        .h_total      (h_total),
        .v_visible    (v_visible),
        .v_frontporch (v_frontporch),
        .v_sync       (v_sync),
        .v_backporch  (v_backporch),
        .v_total      (v_total)
    ) hdmi_video_output_inst (
        .video_clk     (video_clk),
        .rst_n         (rst_n),
        .display_en    (display_en),
        .vga_pclk      (vga_pclk),
        .vga_de        (vga_de),
        .vga_hs        (vga_hs),
        .vga_vs        (vga_vs),
        .vga_rgb       (vga_rgb),
        .rowram_rddata (rowram_rddata),
        .rowram_rdaddr (rowram_rdaddr),
        .palram_rddata (palram_rddata),
        .palram_rdaddr (palram_rdaddr),
        .rowram_swap   (rowram_swap)
    );

endmodule : ppu_video_top

// ==== tests/tb_ppu_video_top.sv ====
module tb_ppu_video_top
    import ppu_video_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Small raster so a frame is 84 x 8 cycles
    localparam int h_visible = 64;
    localparam int h_sync    = 8;
    localparam int h_bp      = 8;
    localparam int h_total   = 84;
    localparam int v_visible = 4;
    localparam int v_sync    = 1;
    localparam int v_bp      = 2;
    localparam int v_total   = 8;
    localparam int h_start   = h_sync + h_bp;  // First visible column
    localparam int v_start   = v_sync + v_bp;
    localparam int row_len   = h_visible / 2;
    localparam int max_cmds  = 64;

    logic        video_clk = 1'b0;
    logic        rst_n;
    host_wr_t    host;
    row_wr_t     row_wr;
    logic        row_swap, vga_pclk, vga_de, vga_hs, vga_vs;
    rgb_t        vga_rgb;
    logic [47:0] cmd_mem [max_cmds];  // {cmd, arg, data} per line
    logic [47:0] host_q [$];          // Host writes held for the next frame
    logic [31:0] pal_model [1024];    // Palette by full 10-bit index
    logic        pal_used [1024];
    pal_index_t  used_q [$];          // Indices that are safe in a row
    pal_index_t  pending_row [row_len];
    pal_index_t  shown_row [row_len];
    integer      seed = 32'h377;
    int          fill_cnt = row_len;  // Row writer idle until first swap
    int          h_cnt, v_cnt, cycles, cycle_limit, fail_cnt;
    int          hs_low, vs_low, de_high, swaps;
    logic        frame_on = 1'b0;
    logic        frame_en = 1'b0;

    ppu_video_top #(
        .h_visible (10'd64), .h_frontporch (10'd4), .h_sync (10'd8),
        .h_backporch (10'd8), .h_total (10'd84),
        .v_visible (10'd4), .v_frontporch (10'd1), .v_sync (10'd1),
        .v_backporch (10'd2), .v_total (10'd8)
    ) ppu_video_top_inst (
        .video_clk (video_clk), .rst_n (rst_n), .host (host), .row_wr (row_wr),
        .row_swap (row_swap), .vga_pclk (vga_pclk), .vga_de (vga_de),
        .vga_hs (vga_hs), .vga_vs (vga_vs), .vga_rgb (vga_rgb)
    );

    always #50 video_clk = !video_clk;  // 100 ns period

    // ======================================================================
    // Failure reporting and compare tasks
    // ======================================================================
    task automatic abort_run(input string msg);
        fail_cnt++;
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp)
            abort_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_sync(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp)
            abort_run($sformatf("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act));
    endtask

    // ======================================================================
    // Raster position, timeout, row writer
    // ======================================================================
    always @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= 0;
            v_cnt <= 0;
        end else if (h_cnt == h_total - 1) begin  // Line ends, step the row
            h_cnt <= 0;
            v_cnt <= (v_cnt == v_total - 1) ? 0 : v_cnt + 1;
        end else begin
            h_cnt <= h_cnt + 1;
        end
    end

    always @(posedge video_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
            abort_run($sformatf("Timeout: run did not end within %0d cycles", cycle_limit));
    end

    // Pixel clock follows video_clk, looked at just after each edge
    always @(posedge video_clk) begin
        #10;
        check_sync("vga_pclk", 1'b1, vga_pclk);
    end

    always @(negedge video_clk) begin
        #10;
        check_sync("vga_pclk", 1'b0, vga_pclk);
    end

    // One index per cycle into the back bank after each swap
    always @(posedge video_clk) begin
        #10;
        row_wr = '0;
        if (fill_cnt < row_len) begin
            row_wr.en   = 1'b1;
            row_wr.addr = fill_cnt[8:0];
            row_wr.data = pending_row[fill_cnt];
            fill_cnt++;
        end
    end

    // Mid-cycle sampling, outputs are stable here
    always @(negedge video_clk) begin : scan_check
        logic        exp_de;
        logic [31:0] entry;
        rgb_t        exp_rgb;
        if (frame_on) begin
            exp_de = h_cnt >= h_start && h_cnt < h_start + h_visible &&
                     v_cnt >= v_start && v_cnt < v_start + v_visible;
            exp_rgb = '0;  // Black unless shown and enabled
            if (exp_de && frame_en) begin
                entry   = pal_model[shown_row[(h_cnt - h_start) / 2]];
                exp_rgb = entry[23:0];
            end
            check_sync("vga_hs", h_cnt >= h_sync, vga_hs);
            check_sync("vga_vs", v_cnt >= v_sync, vga_vs);
            check_sync("vga_de", exp_de, vga_de);
            check_sync("row_swap", h_cnt == h_start - 5, row_swap);
            check_rgb("vga_rgb", exp_rgb, vga_rgb);
            hs_low  += !vga_hs;
            vs_low  += !vga_vs;
            de_high += vga_de;
            swaps   += row_swap;
        end
        if (rst_n && row_swap) begin
            shown_row = pending_row;  // Back bank becomes front
            for (int i = 0; i < row_len; i++) begin
                if (used_q.size() == 0)
                    pending_row[i] = '0;
                else
                    pending_row[i] = used_q[$unsigned($random(seed)) % used_q.size()];
            end
            fill_cnt = 0;
        end
    end

    // ======================================================================
    // Host writes and frames
    // ======================================================================
    task automatic issue_host_cmd(input logic [47:0] word);
        host.en   = 1'b1;
        host.data = word[31:0];
        if (word[47:44] == 4'h2) begin
            host.addr = 11'h400;  // Control register
        end else begin
            host.addr = {1'b0, word[41:32]};
            pal_model[word[41:32]] = word[31:0];
            if (pal_used[word[41:32]] !== 1'b1) begin
                pal_used[word[41:32]] = 1'b1;
                used_q.push_back(word[41:32]);
            end
        end
        @(posedge video_clk);
        #10;
        host = '0;
    endtask

    task automatic run_frame(input logic [31:0] row_seed, input logic exp_en);
        while (!(h_cnt == 0 && v_cnt == 0)) begin
            @(posedge video_clk);
            #10;
        end
        seed     = 32'h377 ^ row_seed;
        frame_en = exp_en;
        hs_low   = 0;
        vs_low   = 0;
        de_high  = 0;
        swaps    = 0;
        frame_on = 1'b1;
        while (host_q.size() > 0)
            issue_host_cmd(host_q.pop_front());  // Lands in vertical blank
        do begin
            @(posedge video_clk);
            #10;
        end while (!(h_cnt == 0 && v_cnt == 0));
        frame_on = 1'b0;
        check_count("hs low cycles", h_sync * v_total, hs_low);
        check_count("vs low cycles", v_sync * h_total, vs_low);
        check_count("de high cycles", h_visible * v_visible, de_high);
        check_count("row_swap pulses", v_total, swaps);
    endtask

    initial begin : run_tests
        int frames;
        rst_n  = 1'b0;
        host   = '0;
        row_wr = '0;
        for (int i = 0; i < max_cmds; i++)
            cmd_mem[i] = '0;
        $readmemh("tests/ppu_video_tests.txt", cmd_mem);
        frames = 0;
        for (int i = 0; i < max_cmds; i++)
            frames += (cmd_mem[i][47:44] == 4'h3);
        if (frames == 0)
            abort_run("No frame commands found in tests/ppu_video_tests.txt");
        cycle_limit = h_total * v_total * (frames + 2);
        repeat (10) begin  // Reset values while rst_n is low
            @(negedge video_clk);
            check_sync("vga_de", 1'b0, vga_de);
            check_sync("row_swap", 1'b0, row_swap);
            check_sync("vga_hs", 1'b0, vga_hs);
            check_sync("vga_vs", 1'b0, vga_vs);
            check_rgb("vga_rgb", '0, vga_rgb);
        end
        @(posedge video_clk);
        #10;
        rst_n = 1'b1;
        for (int i = 0; i < max_cmds && cmd_mem[i][47:44] != 4'h0; i++) begin
            if (cmd_mem[i][47:44] == 4'h3)
                run_frame(cmd_mem[i][31:0], cmd_mem[i][32]);
            else if (cmd_mem[i][47:44] == 4'h1 || cmd_mem[i][47:44] == 4'h2)
                host_q.push_back(cmd_mem[i]);
            else
                abort_run($sformatf("Unknown command in test data line %0d", i));
        end
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_ppu_video_top

// ==== tests/ppu_video_tests.txt ====
// One command per line: cmd _ arg _ data, all hex
// cmd 1 palette write, arg index, data entry {unused, red, green, blue}
// cmd 2 control write, data bit 0 is display_en
// cmd 3 frame, arg bit 0 expected display_en, data row seed
1_000_00ff0000
1_001_0000ff00
1_0fe_000000ff
1_0ff_00ffffff
1_1fe_00123456
1_1ff_a5654321
1_3ff_00808080
1_2aa_000a0b0c
2_000_00000001
3_001_00000001
3_001_0000beef
// Entry 001 rewritten, entry 000 of the same word keeps its colour
1_001_00c0ffee
3_001_00000002
2_000_00000000
3_000_00000003
1_3fe_00abcdef
2_000_00000001
3_001_00000004

// ==== ppu_video_top.f ====
src/ppu_video_pkg.sv
src/video_host_regs.sv
src/ppu_palette_ram.sv
src/ppu_row_buffer.sv
src/hdmi_video_output.sv
src/ppu_video_top.sv
tests/tb_ppu_video_top.sv

// ==== Bender.yml ====
package:
  name: ppu_video

sources:
  - src/ppu_video_pkg.sv
  - src/video_host_regs.sv
  - src/ppu_palette_ram.sv
  - src/ppu_row_buffer.sv
  - src/hdmi_video_output.sv
  - src/ppu_video_top.sv
  - target: test
    files:
      - tests/tb_ppu_video_top.sv
